// ==== decodeExec_params.svh ====
`ifndef DECODEEXEC_PARAMS_SVH
`define DECODEEXEC_PARAMS_SVH

`define DATA_W      32
`define APB_ADDR_W  5
`define RESET_PC    32'h0000_0000

// primary opcodes in instr[31:26]
`define R_TYPE      6'b000000
`define REGIMM_INST 6'b000001
`define J           6'b000010
`define JAL         6'b000011
`define BEQ         6'b000100
`define BNE         6'b000101
`define BLEZ        6'b000110
`define BGTZ        6'b000111
`define ADDIU       6'b001001
`define SLTI        6'b001010
`define SLTIU       6'b001011
`define ANDI        6'b001100
`define ORI         6'b001101
`define XORI        6'b001110
`define LUI         6'b001111

// funct codes in instr[5:0] under R_TYPE
`define SLL         6'b000000
`define SRL         6'b000010
`define JR          6'b001000
`define ADDU        6'b100001
`define SUBU        6'b100011
`define AND         6'b100100
`define OR          6'b100101
`define XOR         6'b100110
`define NOR         6'b100111
`define SLT         6'b101010
`define SLTU        6'b101011

// rt codes under REGIMM_INST
`define BLTZ        5'b00000
`define BGEZ        5'b00001

// apb byte offsets
`define REG_INSTR   5'h00
`define REG_PC      5'h04
`define REG_SEL     5'h08
`define REG_DATA    5'h0C
`define REG_STATUS  5'h10

`endif

// ==== instrPkg.sv ====
package instrPkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluLui,
		aluNone
	} aluOpT;

	typedef enum logic [2:0] {
		brNone,
		brEq,
		brNe,
		brLez,
		brGtz,
		brLtz,
		brGez
	} branchCondT;

	// register 31 for the link of jal
	typedef enum logic [1:0] {dstRd, dstRt, dstRa} regDstT;

	typedef enum logic [1:0] {pcSeq, pcBranch, pcJump, pcJumpReg} nextPcT;

	typedef logic [4:0] regIndexT;

endpackage

// ==== apbPkg.sv ====
`include "decodeExec_params.svh"

package apbPkg;

	typedef enum logic [`APB_ADDR_W-1:0] {
		offInstr  = `REG_INSTR,
		offPc     = `REG_PC,
		offSel    = `REG_SEL,
		offData   = `REG_DATA,
		offStatus = `REG_STATUS
	} regOffsetT;

	// packed msb first so reservedSeen is bit 0
	typedef struct packed {
		logic lastTaken;
		logic reservedSeen;
	} statusT;

endpackage

// ==== mainDecoder.sv ====
`timescale 1ns/1ps
`include "decodeExec_params.svh"

module mainDecoder (
	input logic [`DATA_W-1:0] instrWord,
	output logic regWrite,
	output logic signExt,
	output logic useImm,
	output logic link,
	output logic reserved,
	output instrPkg::regDstT regDst,
	output instrPkg::aluOpT aluOp,
	output instrPkg::branchCondT branchCond,
	output instrPkg::nextPcT nextPc
);
	import instrPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;

	assign opcode = instrWord[31:26];
	assign rs = instrWord[25:21];
	assign rt = instrWord[20:16];
	assign funct = instrWord[5:0];

	assign signExt = (opcode[5:2] != 4'b0011); // andi ori xori lui share 0011xx

	always_comb begin
		regWrite = 1'b0;
		regDst = dstRd;
		useImm = 1'b0;
		link = 1'b0;
		nextPc = pcSeq;
		reserved = 1'b0;
		case (opcode)
			`R_TYPE: begin
				case (funct)
					`ADDU, `SUBU, `AND, `OR, `XOR, `NOR, `SLT, `SLTU: regWrite = 1'b1;
					`SLL, `SRL: begin
						// rotr and other nonzero rs forms stay reserved
						regWrite = (rs == 5'd0);
						reserved = (rs != 5'd0);
					end
					`JR: nextPc = pcJumpReg;
					default: reserved = 1'b1;
				endcase
			end
			`ADDIU, `SLTI, `SLTIU, `ANDI, `ORI, `XORI, `LUI: begin
				regWrite = 1'b1;
				regDst = dstRt;
				useImm = 1'b1;
			end
			`BEQ, `BNE, `BLEZ, `BGTZ: nextPc = pcBranch;
			`REGIMM_INST: begin
				case (rt)
					`BLTZ, `BGEZ: nextPc = pcBranch;
					default: reserved = 1'b1; // link branches too
				endcase
			end
			`J: nextPc = pcJump;
			`JAL: begin
				regWrite = 1'b1;
				regDst = dstRa;
				link = 1'b1;
				nextPc = pcJump;
			end
			default: reserved = 1'b1;
		endcase
	end

	always_comb begin
		case (opcode)
			`R_TYPE: begin
				case (funct)
					`ADDU: aluOp = aluAdd;
					`SUBU: aluOp = aluSub;
					`AND: aluOp = aluAnd;
					`OR: aluOp = aluOr;
					`XOR: aluOp = aluXor;
					`NOR: aluOp = aluNor;
					`SLT: aluOp = aluSlt;
					`SLTU: aluOp = aluSltu;
					`SLL: aluOp = aluSll;
					`SRL: aluOp = aluSrl;
					default: aluOp = aluNone;
				endcase
			end
			`ADDIU: aluOp = aluAdd;
			`SLTI: aluOp = aluSlt;
			`SLTIU: aluOp = aluSltu;
			`ANDI: aluOp = aluAnd;
			`ORI: aluOp = aluOr;
			`XORI: aluOp = aluXor;
			`LUI: aluOp = aluLui;
			default: aluOp = aluNone;
		endcase
	end

	always_comb begin
		case (opcode)
			`BEQ: branchCond = brEq;
			`BNE: branchCond = brNe;
			`BLEZ: branchCond = brLez;
			`BGTZ: branchCond = brGtz;
			`REGIMM_INST: begin
				case (rt)
					`BLTZ: branchCond = brLtz;
					`BGEZ: branchCond = brGez;
					default: branchCond = brNone;
				endcase
			end
			default: branchCond = brNone;
		endcase
	end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps
`include "decodeExec_params.svh"

module regFile (
	input logic clk,
	input logic reset,
	input logic commit,
	input logic regWrite,
	input logic [`DATA_W-1:0] instrWord,
	input instrPkg::regDstT regDst,
	input logic [`DATA_W-1:0] wbData,
	output logic [`DATA_W-1:0] rsData,
	output logic [`DATA_W-1:0] rtData,
	input logic hostWrite,
	input instrPkg::regIndexT hostIndex,
	input logic [`DATA_W-1:0] hostData,
	output logic [`DATA_W-1:0] hostReadData
);
	import instrPkg::*;

	logic [`DATA_W-1:0] regs [32];
	regIndexT rs;
	regIndexT rt;
	regIndexT rd;
	regIndexT dest;

	assign rs = instrWord[25:21];
	assign rt = instrWord[20:16];
	assign rd = instrWord[15:11];

	always_comb begin
		case (regDst)
			dstRt: dest = rt;
			dstRa: dest = 5'd31;
			default: dest = rd;
		endcase
	end

	// entry 0 is cleared by reset and never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (hostWrite && hostIndex != 5'd0) begin
			regs[hostIndex] <= hostData;
		end else if (commit && regWrite && dest != 5'd0) begin
			regs[dest] <= wbData;
		end
	end

	assign rsData = regs[rs];
	assign rtData = regs[rt];
	assign hostReadData = regs[hostIndex];

endmodule

// ==== aluCore.sv ====
`timescale 1ns/1ps
`include "decodeExec_params.svh"

module aluCore (
	input logic [`DATA_W-1:0] instrWord,
	input logic [`DATA_W-1:0] rsData,
	input logic [`DATA_W-1:0] rtData,
	input logic [`DATA_W-1:0] pcPlus4,
	input logic signExt,
	input logic useImm,
	input logic link,
	input instrPkg::aluOpT aluOp,
	output logic [`DATA_W-1:0] wbData
);
	import instrPkg::*;

	logic [15:0] imm;
	logic [4:0] shamt;
	logic [`DATA_W-1:0] immExt;
	logic [`DATA_W-1:0] opB;
	logic [`DATA_W-1:0] aluResult;

	assign imm = instrWord[15:0];
	assign shamt = instrWord[10:6];

	assign immExt = signExt ? {{16{imm[15]}}, imm} : {16'b0, imm};
	assign opB = useImm ? immExt : rtData;

	always_comb begin
		case (aluOp)
			aluAdd: aluResult = rsData + opB;
			aluSub: aluResult = rsData - opB;
			aluAnd: aluResult = rsData & opB;
			aluOr: aluResult = rsData | opB;
			aluXor: aluResult = rsData ^ opB;
			aluNor: aluResult = ~(rsData | opB);
			aluSlt: begin
				aluResult = '0;
				aluResult[0] = $signed(rsData) < $signed(opB);
			end
			aluSltu: begin
				aluResult = '0;
				aluResult[0] = rsData < opB;
			end
			aluSll: aluResult = rtData << shamt; // shifts take rtData instead of opB
			aluSrl: aluResult = rtData >> shamt;
			aluLui: aluResult = {imm, 16'b0};
			default: aluResult = '0;
		endcase
	end

	// jal writes the return address instead
	assign wbData = link ? pcPlus4 : aluResult;

endmodule

// ==== branchUnit.sv ====
`timescale 1ns/1ps
`include "decodeExec_params.svh"

module branchUnit (
	input logic clk,
	input logic reset,
	input logic commit,
	input logic [`DATA_W-1:0] instrWord,
	input logic [`DATA_W-1:0] rsData,
	input logic [`DATA_W-1:0] rtData,
	input instrPkg::branchCondT branchCond,
	input instrPkg::nextPcT nextPc,
	input logic pcWrite,
	input logic [`DATA_W-1:0] pcData,
	output logic [`DATA_W-1:0] pc,
	output logic [`DATA_W-1:0] pcPlus4,
	output logic taken
);
	import instrPkg::*;

	logic [`DATA_W-1:0] offset;
	logic [`DATA_W-1:0] branchTarget;
	logic [`DATA_W-1:0] jumpTarget;
	logic [`DATA_W-1:0] pcNext;
	logic condHolds;
	logic rsZero;

	assign pcPlus4 = pc + 32'd4;
	assign offset = {{14{instrWord[15]}}, instrWord[15:0], 2'b00};
	assign branchTarget = pcPlus4 + offset;
	assign jumpTarget = {pcPlus4[31:28], instrWord[25:0], 2'b00}; // stays in the 256MB region
	assign rsZero = (rsData == '0);

	always_comb begin
		case (branchCond)
			brEq: condHolds = (rsData == rtData);
			brNe: condHolds = (rsData != rtData);
			brLez: condHolds = rsData[31] || rsZero;
			brGtz: condHolds = !rsData[31] && !rsZero;
			brLtz: condHolds = rsData[31];
			brGez: condHolds = !rsData[31];
			default: condHolds = 1'b0;
		endcase
	end

	always_comb begin
		case (nextPc)
			pcBranch: pcNext = condHolds ? branchTarget : pcPlus4;
			pcJump: pcNext = jumpTarget;
			pcJumpReg: pcNext = rsData;
			default: pcNext = pcPlus4;
		endcase
	end

	assign taken = condHolds || nextPc == pcJump || nextPc == pcJumpReg;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RESET_PC;
		end else if (pcWrite) begin
			pc <= pcData;
		end else if (commit) begin
			pc <= pcNext;
		end
	end

endmodule

// ==== apbHost.sv ====
`timescale 1ns/1ps
`include "decodeExec_params.svh"

module apbHost (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_ADDR_W-1:0] paddr,
	input logic [`DATA_W-1:0] pwdata,
	output logic [`DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic reserved,
	input logic taken,
	input logic [`DATA_W-1:0] pc,
	input logic [`DATA_W-1:0] hostReadData,
	output logic [`DATA_W-1:0] instrWord,
	output logic commit,
	output logic hostWrite,
	output logic pcWrite,
	output instrPkg::regIndexT hostIndex,
	output logic [`DATA_W-1:0] hostData,
	output logic [`DATA_W-1:0] pcData
);
	import apbPkg::*;
	import instrPkg::*;

	regOffsetT offset;
	regIndexT selIndex;
	statusT status;
	logic access;
	logic writeAccess;
	logic mapped;
	logic instrStrobe;

	assign offset = regOffsetT'(paddr);
	assign access = psel && penable;
	assign writeAccess = access && pwrite;

	always_comb begin
		case (offset)
			offInstr, offPc, offSel, offData, offStatus: mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
	end

	assign pready = access; // never a wait state
	assign pslverr = access && !mapped;

	assign instrStrobe = writeAccess && offset == offInstr;
	assign commit = instrStrobe && !reserved;
	assign hostWrite = writeAccess && offset == offData;
	assign pcWrite = writeAccess && offset == offPc;

	assign instrWord = pwdata;
	assign hostData = pwdata;
	assign pcData = pwdata;
	assign hostIndex = selIndex;

	always_ff @(posedge clk) begin
		if (reset) begin
			selIndex <= '0;
			status <= '0;
		end else begin
			if (writeAccess && offset == offSel) begin
				selIndex <= pwdata[4:0];
			end
			if (writeAccess && offset == offStatus) begin
				status <= '0; // any value clears
			end else if (instrStrobe) begin
				status.reservedSeen <= status.reservedSeen | reserved;
				status.lastTaken <= taken;
			end
		end
	end

	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			case (offset)
				offPc: prdata = pc;
				offSel: prdata = {{(`DATA_W - 5){1'b0}}, selIndex};
				offData: prdata = hostReadData;
				offStatus: prdata = {{(`DATA_W - $bits(statusT)){1'b0}}, status};
				default: prdata = '0; // instr reads back zero
			endcase
		end
	end

endmodule

// ==== decodeExec.sv ====
`timescale 1ns/1ps
`include "decodeExec_params.svh"

module decodeExec (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_ADDR_W-1:0] paddr,
	input logic [`DATA_W-1:0] pwdata,
	output logic [`DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	import instrPkg::*;

	logic [`DATA_W-1:0] instrWord;
	logic [`DATA_W-1:0] rsData;
	logic [`DATA_W-1:0] rtData;
	logic [`DATA_W-1:0] wbData;
	logic [`DATA_W-1:0] pc;
	logic [`DATA_W-1:0] pcPlus4;
	logic [`DATA_W-1:0] hostData;
	logic [`DATA_W-1:0] hostReadData;
	logic [`DATA_W-1:0] pcData;
	logic commit;
	logic hostWrite;
	logic pcWrite;
	logic regWrite;
	logic signExt;
	logic useImm;
	logic link;
	logic reserved;
	logic taken;
	regIndexT hostIndex;
	regDstT regDst;
	aluOpT aluOp;
	branchCondT branchCond;
	nextPcT nextPc;

	apbHost bus (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.reserved(reserved),
		.taken(taken),
		.pc(pc),
		.hostReadData(hostReadData),
		.instrWord(instrWord),
		.commit(commit),
		.hostWrite(hostWrite),
		.pcWrite(pcWrite),
		.hostIndex(hostIndex),
		.hostData(hostData),
		.pcData(pcData)
	);

	mainDecoder decoder (
		.instrWord(instrWord),
		.regWrite(regWrite),
		.signExt(signExt),
		.useImm(useImm),
		.link(link),
		.reserved(reserved),
		.regDst(regDst),
		.aluOp(aluOp),
		.branchCond(branchCond),
		.nextPc(nextPc)
	);

	regFile regs (
		.clk(clk),
		.reset(reset),
		.commit(commit),
		.regWrite(regWrite),
		.instrWord(instrWord),
		.regDst(regDst),
		.wbData(wbData),
		.rsData(rsData),
		.rtData(rtData),
		.hostWrite(hostWrite),
		.hostIndex(hostIndex),
		.hostData(hostData),
		.hostReadData(hostReadData)
	);

	aluCore alu (
		.instrWord(instrWord),
		.rsData(rsData),
		.rtData(rtData),
		.pcPlus4(pcPlus4),
		.signExt(signExt),
		.useImm(useImm),
		.link(link),
		.aluOp(aluOp),
		.wbData(wbData)
	);

	branchUnit brUnit (
		.clk(clk),
		.reset(reset),
		.commit(commit),
		.instrWord(instrWord),
		.rsData(rsData),
		.rtData(rtData),
		.branchCond(branchCond),
		.nextPc(nextPc),
		.pcWrite(pcWrite),
		.pcData(pcData),
		.pc(pc),
		.pcPlus4(pcPlus4),
		.taken(taken)
	);

endmodule

// ==== decodeExec_tb.sv ====
`timescale 1ns/1ps
`include "decodeExec_params.svh"

module decodeExec_tb;
	localparam int STIM_WORDS = 512;
	localparam int READY_TIMEOUT = 8;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_W-1:0] paddr;
	logic [`DATA_W-1:0] pwdata;
	logic [`DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;

	// each operation takes four words
	logic [31:0] stim [STIM_WORDS];
	int checks;
	int errors;
	int idx;
	int opNum;
	logic finished;
	logic timedOut;
	logic badStim;

	decodeExec dut_i (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("error %s: expected %h, got %h in operation %0d", name, want, got, opNum);
		end
	endtask

	// setup and access phases driven on falling edges
	task automatic apbTransfer(input logic isWrite, input logic [`APB_ADDR_W-1:0] addr,
			input logic [`DATA_W-1:0] wdata, output logic [`DATA_W-1:0] rdata,
			output logic err, output logic ready, output logic [1:0] setupFlags,
			output int cycles);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = isWrite;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		setupFlags = {pslverr, pready}; // both low before the access cycle
		@(negedge clk);
		penable = 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!pready && cycles < READY_TIMEOUT);
		ready = pready;
		rdata = prdata; // stable since reads change no state
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic runOperation(input logic [31:0] op, input logic [31:0] offset,
			input logic [31:0] data, input logic [31:0] expected);
		logic [`DATA_W-1:0] rdata;
		logic err;
		logic ready;
		logic [1:0] setupFlags;
		int cycles;
		apbTransfer(op == 32'd0, offset[`APB_ADDR_W-1:0], data, rdata, err, ready,
			setupFlags, cycles);
		if (!ready) begin
			$display("pready did not rise within %0d cycles in operation %0d",
				READY_TIMEOUT, opNum);
			timedOut = 1'b1;
		end else begin
			checkValue("{pslverr, pready} in setup", {30'b0, setupFlags}, 32'd0);
			checks++;
			assert (cycles == 1) else begin
				errors++;
				$display("operation %0d needed %0d access cycles instead of one", opNum, cycles);
			end
			if (op == 32'd2) begin
				checkValue("pslverr", {31'b0, err}, 32'd1);
			end else begin
				checkValue("pslverr", {31'b0, err}, 32'd0);
			end
			if (op != 32'd0) begin
				checkValue("prdata", rdata, expected);
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		checks = 0;
		errors = 0;
		idx = 0;
		opNum = 0;
		finished = 1'b0;
		timedOut = 1'b0;
		badStim = 1'b0;
		$readmemh("decodeExec_stim.txt", stim);
		repeat (5) @(negedge clk);
		reset = 1'b0;

		while (!finished && !timedOut) begin
			if (idx + 3 >= STIM_WORDS || $isunknown(stim[idx])) begin
				$display("stim file ends without an end marker after operation %0d", opNum);
				badStim = 1'b1;
				finished = 1'b1;
			end else if (stim[idx] == 32'hF) begin
				finished = 1'b1; // end marker
			end else if (stim[idx] > 32'd2) begin
				$display("unknown operation code %h in operation %0d", stim[idx], opNum);
				badStim = 1'b1;
				finished = 1'b1;
			end else begin
				runOperation(stim[idx], stim[idx + 1], stim[idx + 2], stim[idx + 3]);
				idx += 4;
				opNum++;
			end
		end

		$display("operations %0d, checks %0d, errors %0d", opNum, checks, errors);
		if (errors == 0 && !timedOut && !badStim) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== decodeExec_stim.txt ====
// op: 0 write, 1 read, 2 read expecting pslverr, F end of list
// columns: op, byte offset, write data, expected read data, all hex
1 04 00000000 00000000 // pc after reset
1 10 00000000 00000000
0 08 0000001F 00000000
1 0C 00000000 00000000
1 00 00000000 00000000 // instr reads back zero
0 08 00000001 00000000
0 0C FFFFFFF0 00000000 // r1 = -16
0 08 00000002 00000000
0 0C 00000003 00000000 // r2 = 3
1 0C 00000000 00000003
0 00 00221821 00000000 // addu r3, r1, r2
0 00 0022202A 00000000 // slt r4
0 00 0022282B 00000000 // sltu r5
0 00 00023100 00000000 // sll r6, r2, 4
0 00 00013A02 00000000 // srl r7, r1, 8
0 00 00220023 00000000 // subu r0
0 00 2449FFFF 00000000 // addiu r9, r2, -1
0 00 302AFFFF 00000000 // andi r10, r1, 0xffff
0 00 3C0D1234 00000000 // lui r13
1 04 00000000 00000024
0 08 00000003 00000000
1 0C 00000000 FFFFFFF3
0 08 00000004 00000000
1 0C 00000000 00000001
0 08 00000005 00000000
1 0C 00000000 00000000
0 08 00000006 00000000
1 0C 00000000 00000030
0 08 00000007 00000000
1 0C 00000000 00FFFFFF
0 08 00000000 00000000
1 0C 00000000 00000000
0 08 00000009 00000000
1 0C 00000000 00000002
0 08 0000000A 00000000
1 0C 00000000 0000FFF0
0 08 0000000D 00000000
1 0C 00000000 12340000
1 08 00000000 0000000D
0 04 00000100 00000000 // branches start at 0x100
0 00 10420003 00000000 // beq r2, r2 taken
1 04 00000000 00000110
1 10 00000000 00000002
0 00 14420003 00000000 // bne r2, r2 not taken
1 04 00000000 00000114
1 10 00000000 00000000
0 00 1820FFFC 00000000 // blez r1 backward
1 04 00000000 00000108
0 00 1C200003 00000000 // bgtz r1 not taken
1 04 00000000 0000010C
0 00 04400003 00000000 // bltz r2 not taken
1 04 00000000 00000110
0 00 04410003 00000000 // bgez r2 taken
1 04 00000000 00000120
0 00 10220003 00000000 // beq r1, r2 not taken
1 04 00000000 00000124
0 00 14220003 00000000 // bne r1, r2 taken
1 04 00000000 00000134
1 10 00000000 00000002
0 00 18400003 00000000 // blez r2 not taken
1 04 00000000 00000138
0 00 1C400003 00000000 // bgtz r2 taken
1 04 00000000 00000148
0 00 04200003 00000000 // bltz r1 taken
1 04 00000000 00000158
0 00 04210003 00000000 // bgez r1 not taken
1 04 00000000 0000015C
1 10 00000000 00000000
0 00 08000040 00000000 // j 0x100
1 04 00000000 00000100
0 00 0C000080 00000000 // jal 0x200
1 04 00000000 00000200
0 08 0000001F 00000000
1 0C 00000000 00000104
0 00 00C00008 00000000 // jr r6
1 04 00000000 00000030
1 10 00000000 00000002
0 10 00000000 00000000
1 10 00000000 00000000
0 00 8C220000 00000000 // lw r2, 0(r1)
0 00 00220018 00000000 // mult r1, r2
0 00 FC000000 00000000 // opcode 0x3f
1 04 00000000 00000030
0 08 00000002 00000000
1 0C 00000000 00000003
1 10 00000000 00000001
0 10 FFFFFFFF 00000000
1 10 00000000 00000000
2 14 00000000 00000000 // unmapped
2 1C 00000000 00000000
F 00 00000000 00000000

// ==== decodeExec.f ====
+incdir+.
instrPkg.sv
apbPkg.sv
mainDecoder.sv
regFile.sv
aluCore.sv
branchUnit.sv
apbHost.sv
decodeExec.sv
decodeExec_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the decodeExec testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert --top-module decodeExec_tb -f decodeExec.f -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
	exit 0
fi
exit 1
